// File: list.f
rtl/mesh_pkg.sv
rtl/mmu_pkg.sv
rtl/mmu_cfg_write.sv
rtl/mmu_table.sv
rtl/mmu_ctrl.sv
rtl/addr_remap.sv
rtl/emmu_top.sv
tests/emmu_tb.sv

// File: tests/emmu_tb.sv
////////////////////
// address translation testbench
////////////////////

`timescale 1ns/1ns

module emmu_tb;

   localparam int MAW         = 12;
   localparam int N_ENT       = 16;    // entries in use
   localparam int N_RAND      = 200;   // random translate cycles
   localparam int N_FULL      = 40;    // full rate packets
   localparam int N_BYP       = 60;    // cycles per bypass mode
   localparam int N_TRANS     = 2 * N_ENT + N_RAND + N_FULL + 2 + 2 * N_BYP;
   localparam int TIMEOUT_CYC = N_TRANS * 20 + 10;   // plus reset

   logic                   rd_clk;
   logic                   reset;
   logic                   mmu_en;
   logic                   mmu_bp;
   logic                   cfg_valid;
   mmu_pkg::mmu_cfg_t      cfg;
   logic                   in_valid;
   mesh_pkg::mesh_packet_t in_pkt;
   logic                   out_ready;
   logic                   in_ready;
   logic                   out_valid;
   mesh_pkg::mesh_xlat_t   out_xlat;

   integer                 seed = 32'h4a1b9eba;
   logic [31:0]            model_lo [4096];   // mirror of entry bits 31..0
   logic [15:0]            model_hi [4096];   // mirror of entry bits 47..32
   logic [MAW-1:0]         idx_tab [N_ENT];   // entries the traffic uses
   mesh_pkg::mesh_xlat_t   exp_q [$];
   int                     cyc_q [$];         // acceptance cycle per packet
   int                     val_errs = 0;
   int                     proto_errs = 0;
   int                     cycle = 0;
   logic                   in_taken = 1'b0;
   logic                   stalled = 1'b0;
   logic                   full_rate = 1'b0;  // throughput phase
   mesh_pkg::mesh_xlat_t   stall_val;
   mesh_pkg::mesh_xlat_t   exp_x;
   int                     exp_cyc;

   emmu_top #(.MAW(MAW)) dut0 (.*);

   initial
   begin
      rd_clk = 1'b0;
      forever #4 rd_clk = ~rd_clk;
   end

   // reference result where the upper 12 bits pick the entry
   function automatic mesh_pkg::mesh_xlat_t expect_xlat(mesh_pkg::mesh_packet_t p, logic xl);
      logic [11:0]          idx;
      logic [47:0]          ent;
      logic [63:0]          a;
      mesh_pkg::mesh_xlat_t r;
      idx = p.dstaddr[31:20];
      ent = {model_hi[idx], model_lo[idx]};
      if (xl)
         a = {ent[43:0], p.dstaddr[19:0]};   // entry then page offset
      else
         a = {32'h0, p.dstaddr};
      r.packet         = p;
      r.packet.dstaddr = a[31:0];
      r.dst_hi         = a[63:32];
      return r;
   endfunction

   function automatic mesh_pkg::mesh_packet_t rand_packet();
      mesh_pkg::mesh_packet_t p;
      int                     k;
      k         = $unsigned($random(seed)) % N_ENT;
      p.srcaddr = $random(seed);
      p.data    = $random(seed);
      p.dstaddr = {idx_tab[k], 20'($random(seed))};
      p.ctrl    = 8'($random(seed));
      return p;
   endfunction

   // one cycle of random traffic and table writes
   task automatic drive_random();
      int k;
      @(negedge rd_clk);
      if (!(in_valid && !in_taken))   // an open offer stays as it is
      begin
         in_valid = 1'($random(seed));
         in_pkt   = rand_packet();
      end
      out_ready = (($random(seed) & 3) != 0);
      cfg_valid = (($random(seed) & 3) == 0);
      k         = $unsigned($random(seed)) % N_ENT;
      cfg.addr  = {idx_tab[k], 1'($random(seed)), 2'b00};
      cfg.data  = $random(seed);
   endtask

   task automatic drain();
      @(negedge rd_clk);
      in_valid  = 1'b0;
      cfg_valid = 1'b0;
      out_ready = 1'b1;
      @(negedge rd_clk);
      while (out_valid)
         @(negedge rd_clk);
   endtask

   // transfers and model updates on the rising edge
   always @(posedge rd_clk)
   begin
      if (!reset)
      begin
         cycle++;
         if (stalled)
            assert (out_xlat === stall_val)
            else
            begin
               $display("out_xlat changed while out_ready was low at %0t", $time);
               proto_errs++;
            end
         stalled   = out_valid && !out_ready;
         stall_val = out_xlat;
         if (full_rate)
            assert (in_ready)
            else
            begin
               $display("in_ready dropped at full rate at %0t", $time);
               proto_errs++;
            end
         if (out_valid && out_ready)
         begin
            if (exp_q.size() == 0)
            begin
               $display("output at %0t with no accepted packet pending", $time);
               proto_errs++;
            end
            else
            begin
               exp_x   = exp_q.pop_front();
               exp_cyc = cyc_q.pop_front();
               assert (out_xlat === exp_x)
               else
               begin
                  $display("ERR %0t out_xlat expected %h got %h", $time, exp_x, out_xlat);
                  val_errs++;
               end
               assert (!full_rate || exp_cyc == cycle - 1)
               else
               begin
                  $display("packet left %0d cycles after acceptance", cycle - exp_cyc);
                  proto_errs++;
               end
            end
         end
         in_taken = in_valid && in_ready;
         if (in_taken)   // lookup sees the entry before this edge's write
         begin
            exp_q.push_back(expect_xlat(in_pkt, mmu_en && !mmu_bp));
            cyc_q.push_back(cycle);
         end
         if (cfg_valid)
         begin
            if (cfg.addr[2])
               model_hi[cfg.addr[14:3]] = cfg.data[15:0];
            else
               model_lo[cfg.addr[14:3]] = cfg.data;
         end
      end
   end

   initial
   begin
      reset     = 1'b1;
      mmu_en    = 1'b0;
      mmu_bp    = 1'b0;
      cfg_valid = 1'b0;
      cfg       = '0;
      in_valid  = 1'b0;
      in_pkt    = '0;
      out_ready = 1'b0;
      repeat (10) @(posedge rd_clk);
      @(negedge rd_clk);
      reset = 1'b0;
      @(negedge rd_clk);
      assert (!out_valid && in_ready)
      else
      begin
         $display("out_valid or in_ready wrong after reset");
         proto_errs++;
      end
      for (int i = 0; i < N_ENT; i++)
         idx_tab[i] = MAW'($random(seed));
      // both halves of every entry in use
      for (int i = 0; i < 2 * N_ENT; i++)
      begin
         @(negedge rd_clk);
         cfg_valid = 1'b1;
         cfg.addr  = {idx_tab[i / 2], 1'(i), 2'b00};
         cfg.data  = $random(seed);
      end
      @(negedge rd_clk);
      cfg_valid = 1'b0;
      mmu_en    = 1'b1;
      repeat (N_RAND) drive_random();
      drain();
      full_rate = 1'b1;
      repeat (N_FULL)
      begin
         @(negedge rd_clk);
         in_valid = 1'b1;
         in_pkt   = rand_packet();
      end
      drain();
      full_rate = 1'b0;
      // write and lookup of one entry at the same edge and a later lookup
      @(negedge rd_clk);
      in_pkt                     = rand_packet();
      in_pkt.dstaddr[31 -: MAW]  = idx_tab[0];
      in_valid                   = 1'b1;
      cfg_valid                  = 1'b1;
      cfg.addr                   = {idx_tab[0], 1'b0, 2'b00};
      cfg.data                   = ~model_lo[idx_tab[0]];   // differs from old
      @(negedge rd_clk);
      cfg_valid                  = 1'b0;
      in_pkt                     = rand_packet();
      in_pkt.dstaddr[31 -: MAW]  = idx_tab[0];
      drain();
      mmu_en = 1'b0;
      repeat (N_BYP) drive_random();
      drain();
      mmu_en = 1'b1;
      mmu_bp = 1'b1;
      repeat (N_BYP) drive_random();
      drain();
      assert (exp_q.size() == 0)
      else
      begin
         $display("%0d accepted packets never came out", exp_q.size());
         proto_errs++;
      end
      $display("errors: %0d value, %0d protocol", val_errs, proto_errs);
      if (val_errs == 0 && proto_errs == 0)
         $display("Everything OK");
      else
         $display("Something failed");
      $finish;
   end

   // watchdog
   initial
   begin
      #(TIMEOUT_CYC * 8);
      $display("test timed out after %0d cycles", TIMEOUT_CYC);
      $display("errors: %0d value, %0d protocol", val_errs, proto_errs + 1);
      $display("Something failed");
      $finish;
   end

endmodule

// File: rtl/emmu_top.sv
////////////////////
// mesh address translation
////////////////////

`timescale 1ns/1ns

module emmu_top #(
   parameter int MAW = 12   // table index width
) (
   input  logic                   rd_clk,
   input  logic                   reset,       // async, active high
   input  logic                   mmu_en,      // static, translate enable
   input  logic                   mmu_bp,      // static, bypass
   input  logic                   cfg_valid,   // table write beat
   input  mmu_pkg::mmu_cfg_t      cfg,
   input  logic                   in_valid,
   input  mesh_pkg::mesh_packet_t in_pkt,
   input  logic                   out_ready,
   output logic                   in_ready,
   output logic                   out_valid,
   output mesh_pkg::mesh_xlat_t   out_xlat
);

   logic                   lookup_en;
   logic [MAW-1:0]         lookup_index;   // top bits of the destination
   logic [MAW-1:0]         wr_index;
   mmu_pkg::mmu_half_we_t  wr_half;
   mmu_pkg::mmu_entry_t    wr_data;
   mmu_pkg::mmu_entry_t    entry;
   mesh_pkg::mesh_packet_t held_pkt;
   logic                   held_xlat_en;

   assign lookup_index = in_pkt.dstaddr[31 -: MAW];

   mmu_ctrl ctrl0 (
      .rd_clk       (rd_clk),
      .reset        (reset),
      .in_valid     (in_valid),
      .in_pkt       (in_pkt),
      .out_ready    (out_ready),
      .mmu_en       (mmu_en),
      .mmu_bp       (mmu_bp),
      .in_ready     (in_ready),
      .lookup_en    (lookup_en),
      .out_valid    (out_valid),
      .held_pkt     (held_pkt),
      .held_xlat_en (held_xlat_en)
   );

   mmu_cfg_write #(.MAW(MAW)) cfgw0 (
      .cfg_valid (cfg_valid),
      .cfg       (cfg),
      .wr_index  (wr_index),
      .wr_half   (wr_half),
      .wr_data   (wr_data)
   );

   // lookup issued on the input transfer
   mmu_table #(.MAW(MAW)) table0 (
      .rd_clk       (rd_clk),
      .wr_index     (wr_index),
      .wr_half      (wr_half),
      .wr_data      (wr_data),
      .lookup_en    (lookup_en),
      .lookup_index (lookup_index),
      .entry        (entry)
   );

   addr_remap remap0 (
      .held_pkt     (held_pkt),
      .held_xlat_en (held_xlat_en),
      .entry        (entry),
      .out_xlat     (out_xlat)
   );

endmodule

// File: rtl/addr_remap.sv
////////////////////
// destination remap
////////////////////

`timescale 1ns/1ns

module addr_remap (
   input  mesh_pkg::mesh_packet_t held_pkt,       // packet from the stage
   input  logic                   held_xlat_en,   // translate this one
   input  mmu_pkg::mmu_entry_t    entry,          // table entry for it
   output mesh_pkg::mesh_xlat_t   out_xlat        // rewritten packet
);

   logic [63:0] dst_full;   // 64 bit destination
   logic [19:0] page_off;   // offset kept through translation

   assign page_off = held_pkt.dstaddr[19:0];

   // entry bits 47..44 are not part of the address
   always_comb
   begin
      if (held_xlat_en)
         dst_full = {entry[43:0], page_off};
      else
         dst_full = {32'h0, held_pkt.dstaddr};   // pass through with zero high word
   end

   // everything but dstaddr rides along untouched
   always_comb
   begin
      out_xlat.packet         = held_pkt;
      out_xlat.packet.dstaddr = dst_full[31:0];
      out_xlat.dst_hi         = dst_full[63:32];
   end

endmodule

// File: rtl/mmu_ctrl.sv
////////////////////
// lookup pipeline control
////////////////////

`timescale 1ns/1ns

module mmu_ctrl (
   input  logic                   rd_clk,
   input  logic                   reset,          // async active high
   input  logic                   in_valid,       // source has a packet
   input  mesh_pkg::mesh_packet_t in_pkt,         // incoming packet
   input  logic                   out_ready,      // sink takes the output
   input  logic                   mmu_en,         // static translate enable
   input  logic                   mmu_bp,         // static bypass
   output logic                   in_ready,       // stage can take a packet
   output logic                   lookup_en,      // table read strobe
   output logic                   out_valid,      // held packet is valid
   output mesh_pkg::mesh_packet_t held_pkt,       // packet in the stage
   output logic                   held_xlat_en    // translate decision for it
);

   logic accept;   // input transfer this edge
   logic xlat_now; // decision sampled with the packet

   // free slot or the held packet leaves this cycle
   assign in_ready  = !out_valid || out_ready;
   assign accept    = in_valid && in_ready;
   assign xlat_now  = mmu_en && !mmu_bp;

   // table read lines up with the registered packet
   assign lookup_en = accept;

   // occupancy and the decision bit
   always_ff @(posedge rd_clk or posedge reset)
   begin
      if (reset)
      begin
         out_valid    <= 1'b0;
         held_xlat_en <= 1'b0;
      end
      else
      begin
         if (in_ready)
            out_valid <= in_valid;   // refill or drain
         if (accept)
            held_xlat_en <= xlat_now;
      end
   end

   // payload register
   always_ff @(posedge rd_clk)
   begin
      if (accept)
         held_pkt <= in_pkt;
   end

   // an offered packet stays offered until taken
   a_valid_hold: assert property (@(posedge rd_clk) disable iff (reset)
      out_valid && !out_ready |=> out_valid)
      else $error("out_valid dropped without out_ready");

   // payload and decision frozen under back-pressure
   a_pkt_stable: assert property (@(posedge rd_clk) disable iff (reset)
      out_valid && !out_ready |=> $stable(held_pkt) && $stable(held_xlat_en))
      else $error("held packet changed while stalled");

endmodule

// File: rtl/mmu_table.sv
////////////////////
// translation table
////////////////////

`timescale 1ns/1ns

module mmu_table #(
   parameter int MAW = 12   // 2**MAW entries
) (
   input  logic                  rd_clk,
   input  logic [MAW-1:0]        wr_index,       // write entry
   input  mmu_pkg::mmu_half_we_t wr_half,        // half enables
   input  mmu_pkg::mmu_entry_t   wr_data,        // aligned write word
   input  logic                  lookup_en,      // read strobe
   input  logic [MAW-1:0]        lookup_index,   // read entry
   output mmu_pkg::mmu_entry_t   entry           // registered read data
);

   localparam int DEPTH = 2 ** MAW;

   // split storage so each half writes on its own
   logic [31:0] mem_lo [DEPTH];   // entry bits 31..0
   logic [15:0] mem_hi [DEPTH];   // entry bits 47..32

   // write port
   always_ff @(posedge rd_clk)
   begin
      if (wr_half[0])
         mem_lo[wr_index] <= wr_data[31:0];
      if (wr_half[1])
         mem_hi[wr_index] <= wr_data[47:32];
   end

   // read port, read-first on a same-edge write
   // holds its value while no lookup is issued
   always_ff @(posedge rd_clk)
   begin
      if (lookup_en)
         entry <= {mem_hi[lookup_index], mem_lo[lookup_index]};
   end

   // decoder must never strobe both halves of one beat
   a_half_onehot: assert property (@(posedge rd_clk) wr_half != 2'b11)
      else $error("table write hit both halves at once");

endmodule

// File: rtl/mmu_cfg_write.sv
////////////////////
// table write decoder
////////////////////

`timescale 1ns/1ns

module mmu_cfg_write #(
   parameter int MAW = 12   // table index width, at most 12
) (
   input  logic                 cfg_valid,   // write strobe
   input  mmu_pkg::mmu_cfg_t    cfg,         // address and data of the beat
   output logic [MAW-1:0]       wr_index,    // entry to write
   output mmu_pkg::mmu_half_we_t wr_half,    // one-hot half enable
   output mmu_pkg::mmu_entry_t  wr_data      // data aligned to both halves
);

   logic hi_sel;   // 1 = high half of the entry

   // index sits right above the half select
   assign wr_index = cfg.addr[3 +: MAW];
   assign hi_sel   = cfg.addr[2];

   // one-hot, and quiet without a beat
   always_comb
   begin
      wr_half = 2'b00;
      if (cfg_valid)
      begin
         if (hi_sel)
            wr_half = 2'b10;   // entry bits 47..32
         else
            wr_half = 2'b01;   // entry bits 31..0
      end
   end

   // same word lands in both halves
   // the table keeps only the enabled one
   assign wr_data = {cfg.data[15:0], cfg.data};   // 16 + 32 bits

endmodule

// File: rtl/mmu_pkg.sv
////////////////////
// translation table types
////////////////////

package mmu_pkg;

   // table entry, only 43..0 go into the address
   typedef logic [47:0] mmu_entry_t;

   // config address
   // 14..3 entry index, 2 picks the half
   typedef logic [14:0] mmu_cfg_addr_t;

   // per-half write strobe
   typedef logic [1:0] mmu_half_we_t;   // bit 0 low word, bit 1 high word

   // one configuration beat
   typedef struct packed {
      mmu_cfg_addr_t       addr;
      mesh_pkg::mesh_data_t data;
   } mmu_cfg_t;

endpackage

// File: rtl/mesh_pkg.sv
////////////////////
// mesh packet format
////////////////////

package mesh_pkg;

   // plain widths with a meaning
   typedef logic [31:0] mesh_addr_t;   // mesh byte address
   typedef logic [31:0] mesh_data_t;   // one data word
   typedef logic [7:0]  mesh_ctrl_t;   // bit 1 marks a write

   // 104 bit mesh packet, srcaddr on top
   typedef struct packed {
      mesh_addr_t srcaddr;   // [103:72]
      mesh_data_t data;      // [71:40]
      mesh_addr_t dstaddr;   // [39:8]
      mesh_ctrl_t ctrl;      // [7:0]
   } mesh_packet_t;

   // translated packet with the upper address word alongside
   typedef struct packed {
      mesh_addr_t   dst_hi;   // bits 63..32 of the new address
      mesh_packet_t packet;   // dstaddr holds bits 31..0
   } mesh_xlat_t;

endpackage
